/* Bender.yml */
package:
  name: core_mem

sources:
  - files:
      - logic/core_mem_pkg.sv
      - logic/sp_ram.sv
      - logic/host_word_port.sv
      - logic/weight_bank.sv
      - logic/kv_cache_bank.sv
      - logic/kv_clean_fsm.sv
      - logic/sweep_counter.sv
      - logic/core_mem.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/core_mem_tb.sv

/* core_mem.f */
+incdir+tb
logic/core_mem_pkg.sv
logic/sp_ram.sv
logic/host_word_port.sv
logic/weight_bank.sv
logic/kv_cache_bank.sv
logic/kv_clean_fsm.sv
logic/sweep_counter.sv
logic/core_mem.sv
tb/core_mem_tb.sv

/* logic/core_mem.sv */
module core_mem
	import core_mem_pkg::*;
#(
	parameter int WMEM_DEPTH = 1536,
	parameter int KV_USER_DEPTH = 128,
	parameter int MAX_USERS = 4
) (
	input  logic clk,
	input  logic rstn,
	input  host_req_t host,
	output logic [WORD_W-1:0] host_rdata,
	output logic host_rvld,
	input  cmem_req_t cmem,
	output logic [LINE_W-1:0] cmem_rdata,
	output logic cmem_rvalid,
	input  logic [USER_W-1:0] active_user,
	input  logic clean_kv,
	input  logic [USER_W-1:0] clean_user,
	output logic clean_done
);

	localparam int KV_ROW_W = $clog2(KV_USER_DEPTH * MAX_USERS);

	ram_req_t wm_host_req;
	ram_req_t kv_host_req;
	cmem_req_t wm_cmem;
	cmem_req_t kv_cmem;
	logic [LINE_W-1:0] wm_rdata;
	logic [LINE_W-1:0] kv_rdata;
	logic [WORD_W-1:0] wm_word;
	logic [WORD_W-1:0] kv_word;
	logic wm_word_vld;
	logic kv_word_vld;
	logic wm_cmem_rvalid;
	logic kv_cmem_rvalid;
	logic sweep_load;
	logic sweep_run;
	logic sweep_last;
	logic clean_busy;
	logic [KV_ROW_W-1:0] clean_row;

	// Steer compute requests by the top address bit
	always_comb begin
		wm_cmem = cmem;
		kv_cmem = cmem;
		wm_cmem.wen = cmem.wen && !cmem.addr[CMEM_ADDR_W-1];
		wm_cmem.ren = cmem.ren && !cmem.addr[CMEM_ADDR_W-1];
		kv_cmem.wen = cmem.wen && cmem.addr[CMEM_ADDR_W-1];
		kv_cmem.ren = cmem.ren && cmem.addr[CMEM_ADDR_W-1];
	end

	host_word_port #(.IS_KV(1'b0)) u_wm_port (
		.clk(clk),
		.rstn(rstn),
		.host(host),
		.line_req(wm_host_req),
		.line_rdata(wm_rdata),
		.word(wm_word),
		.word_vld(wm_word_vld)
	);

	host_word_port #(.IS_KV(1'b1)) u_kv_port (
		.clk(clk),
		.rstn(rstn),
		.host(host),
		.line_req(kv_host_req),
		.line_rdata(kv_rdata),
		.word(kv_word),
		.word_vld(kv_word_vld)
	);

	weight_bank #(.WMEM_DEPTH(WMEM_DEPTH)) u_weight_bank (
		.clk(clk),
		.rstn(rstn),
		.host_req(wm_host_req),
		.cmem_req(wm_cmem),
		.rdata(wm_rdata),
		.cmem_rvalid(wm_cmem_rvalid)
	);

	kv_cache_bank #(
		.KV_USER_DEPTH(KV_USER_DEPTH),
		.MAX_USERS(MAX_USERS)
	) u_kv_bank (
		.clk(clk),
		.rstn(rstn),
		.host_req(kv_host_req),
		.cmem_req(kv_cmem),
		.active_user(active_user),
		.clean_row(clean_row),
		.clean_wen(sweep_run),
		.clean_busy(clean_busy),
		.rdata(kv_rdata),
		.cmem_rvalid(kv_cmem_rvalid)
	);

	kv_clean_fsm #(.MAX_USERS(MAX_USERS)) u_clean_fsm (
		.clk(clk),
		.rstn(rstn),
		.clean_kv(clean_kv),
		.clean_user(clean_user),
		.last_row(sweep_last),
		.load(sweep_load),
		.run(sweep_run),
		.clean_busy(clean_busy),
		.clean_done(clean_done)
	);

	sweep_counter #(
		.KV_USER_DEPTH(KV_USER_DEPTH),
		.MAX_USERS(MAX_USERS)
	) u_sweep (
		.clk(clk),
		.rstn(rstn),
		.load(sweep_load),
		.run(sweep_run),
		.user(clean_user),
		.row(clean_row),
		.last_row(sweep_last)
	);

	// Cache returns take precedence
	always_comb begin
		host_rvld = kv_word_vld || wm_word_vld;
		host_rdata = '0;
		if (kv_word_vld) begin
			host_rdata = kv_word;
		end else if (wm_word_vld) begin
			host_rdata = wm_word;
		end
	end

	always_comb begin
		cmem_rvalid = kv_cmem_rvalid || wm_cmem_rvalid;
		cmem_rdata = '0;
		if (kv_cmem_rvalid) begin
			cmem_rdata = kv_rdata;
		end else if (wm_cmem_rvalid) begin
			cmem_rdata = wm_rdata;
		end
	end

endmodule

/* logic/core_mem_pkg.sv */
package core_mem_pkg;

	localparam int LANE_W = 8;
	localparam int LANES = 16;
	localparam int LINE_W = LANE_W * LANES;
	localparam int WORD_W = 16;
	localparam int WORDS_PER_LINE = LINE_W / WORD_W;
	localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);
	localparam int HOST_ADDR_W = 14;
	localparam int CMEM_ADDR_W = 12;
	localparam int USER_W = 2;
	// Wide enough for the 1536-row weight memory
	localparam int RAM_ROW_W = 11;

	// Weight view, regions 1 to 3
	typedef struct packed {
		logic [1:0] region;
		logic [HOST_ADDR_W-2-WORD_IDX_W-1:0] row;
		logic [WORD_IDX_W-1:0] word;
	} wmem_host_addr_t;

	// Cache view, region 0 only
	typedef struct packed {
		logic [1:0] region;
		logic [USER_W-1:0] user;
		logic [HOST_ADDR_W-2-USER_W-WORD_IDX_W-1:0] row;
		logic [WORD_IDX_W-1:0] word;
	} kv_host_addr_t;

	typedef union packed {
		wmem_host_addr_t wmem;
		kv_host_addr_t kv;
	} host_addr_u;

	typedef struct packed {
		logic wen;
		logic ren;
		host_addr_u addr;
		logic [WORD_W-1:0] wdata;
	} host_req_t;

	// Top address bit picks the cache
	typedef struct packed {
		logic wen;
		logic ren;
		logic [CMEM_ADDR_W-1:0] addr;
		logic [LINE_W-1:0] data;
	} cmem_req_t;

	typedef struct packed {
		logic wen;
		logic ren;
		logic [RAM_ROW_W-1:0] row;
		logic [LINE_W-1:0] data;
		logic [LINE_W-1:0] ben;
	} ram_req_t;

endpackage

/* logic/host_word_port.sv */
module host_word_port
	import core_mem_pkg::*;
#(
	parameter bit IS_KV = 1'b0
) (
	input  logic clk,
	input  logic rstn,
	input  host_req_t host,
	output ram_req_t line_req,
	input  logic [LINE_W-1:0] line_rdata,
	output logic [WORD_W-1:0] word,
	output logic word_vld
);

	logic hit;
	logic [RAM_ROW_W-1:0] row;
	logic [WORD_IDX_W-1:0] idx;
	logic [LINE_W-1:0] ben;
	logic wen_q;
	logic ren_q;
	logic [RAM_ROW_W-1:0] row_q;
	logic [LINE_W-1:0] data_q;
	logic [LINE_W-1:0] ben_q;
	logic [WORD_IDX_W-1:0] idx_q1;
	logic [WORD_IDX_W-1:0] idx_q2;

	always_comb begin
		if (IS_KV) begin
			hit = host.addr.kv.region == 2'd0;
			row = RAM_ROW_W'({host.addr.kv.user, host.addr.kv.row});
			idx = host.addr.kv.word;
		end else begin
			// Region 1 maps to weight row 0
			hit = host.addr.wmem.region != 2'd0;
			row = {host.addr.wmem.region - 2'd1, host.addr.wmem.row};
			idx = host.addr.wmem.word;
		end
		ben = '0;
		ben[idx * WORD_W +: WORD_W] = '1;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wen_q <= 1'b0;
			ren_q <= 1'b0;
			word_vld <= 1'b0;
		end else begin
			wen_q <= host.wen && hit;
			ren_q <= host.ren && hit;
			word_vld <= ren_q;
		end
	end

	always_ff @(posedge clk) begin
		row_q <= row;
		data_q <= {WORDS_PER_LINE{host.wdata}};
		ben_q <= ben;
		idx_q1 <= idx;
		idx_q2 <= idx_q1;
	end

	always_comb begin
		line_req.wen = wen_q;
		line_req.ren = ren_q;
		line_req.row = row_q;
		line_req.data = data_q;
		line_req.ben = ben_q;
	end

	// Word lines up with the registered RAM output
	assign word = line_rdata[idx_q2 * WORD_W +: WORD_W];

endmodule

/* logic/kv_cache_bank.sv */
module kv_cache_bank
	import core_mem_pkg::*;
#(
	parameter int KV_USER_DEPTH = 128,
	parameter int MAX_USERS = 4
) (
	input  logic clk,
	input  logic rstn,
	input  ram_req_t host_req,
	input  cmem_req_t cmem_req,
	input  logic [USER_W-1:0] active_user,
	input  logic [$clog2(KV_USER_DEPTH * MAX_USERS)-1:0] clean_row,
	input  logic clean_wen,
	input  logic clean_busy,
	output logic [LINE_W-1:0] rdata,
	output logic cmem_rvalid
);

	localparam int USER_ROW_W = $clog2(KV_USER_DEPTH);
	localparam int LANE_SEL_W = $clog2(LANES);

	logic [RAM_ROW_W-1:0] slot_base;
	logic [RAM_ROW_W-1:0] cmem_row;
	logic [LANE_SEL_W-1:0] lane;
	logic [LINE_W-1:0] lane_mask;
	logic cw_wen;
	logic [RAM_ROW_W-1:0] cw_row;
	logic [LINE_W-1:0] cw_data;
	logic [LINE_W-1:0] cw_ben;
	logic grant_rd;
	ram_req_t ram_req;

	// Rows of the active user's slot
	assign slot_base = RAM_ROW_W'(active_user) * RAM_ROW_W'(KV_USER_DEPTH);
	assign cmem_row = slot_base + RAM_ROW_W'(cmem_req.addr[USER_ROW_W-1:0]);
	assign lane = cmem_req.addr[USER_ROW_W +: LANE_SEL_W];

	always_comb begin
		lane_mask = '0;
		lane_mask[lane * LANE_W +: LANE_W] = '1;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cw_wen <= 1'b0;
			cmem_rvalid <= 1'b0;
		end else begin
			cw_wen <= cmem_req.wen;
			cmem_rvalid <= grant_rd;
		end
	end

	// Low byte lands in the addressed lane
	always_ff @(posedge clk) begin
		if (cmem_req.wen) begin
			cw_row <= cmem_row;
			cw_data <= {LANES{cmem_req.data[LANE_W-1:0]}};
			cw_ben <= lane_mask;
		end
	end

	always_comb begin
		ram_req = '0;
		grant_rd = 1'b0;
		if (clean_busy) begin
			// Sweep writes zero rows only
			ram_req.wen = clean_wen;
			ram_req.row = RAM_ROW_W'(clean_row);
			ram_req.ben = '1;
		end else if (host_req.wen || host_req.ren) begin
			ram_req = host_req;
		end else if (cw_wen) begin
			ram_req.wen = 1'b1;
			ram_req.row = cw_row;
			ram_req.data = cw_data;
			ram_req.ben = cw_ben;
		end else if (cmem_req.ren) begin
			ram_req.ren = 1'b1;
			ram_req.row = cmem_row;
			grant_rd = 1'b1;
		end
	end

	sp_ram #(
		.DEPTH(KV_USER_DEPTH * MAX_USERS),
		.ADDR_W($clog2(KV_USER_DEPTH * MAX_USERS))
	) u_ram (
		.clk(clk),
		.req(ram_req),
		.rdata(rdata)
	);

endmodule

/* logic/kv_clean_fsm.sv */
module kv_clean_fsm
	import core_mem_pkg::*;
#(
	parameter int MAX_USERS = 4
) (
	input  logic clk,
	input  logic rstn,
	input  logic clean_kv,
	input  logic [USER_W-1:0] clean_user,
	input  logic last_row,
	output logic load,
	output logic run,
	output logic clean_busy,
	output logic clean_done
);

	typedef enum logic [1:0] {
		st_idle,
		st_sweep,
		st_done
	} state_t;

	state_t state;
	state_t state_nxt;
	logic accept;

	// Users beyond the slot count are refused
	assign accept = clean_kv && (int'(clean_user) < MAX_USERS);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (accept) state_nxt = st_sweep;
			st_sweep: if (last_row) state_nxt = st_done;
			st_done: state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	assign load = (state == st_idle) && accept;
	assign run = state == st_sweep;
	assign clean_busy = state != st_idle;
	assign clean_done = state == st_done;

endmodule

/* logic/sp_ram.sv */
module sp_ram
	import core_mem_pkg::*;
#(
	parameter int DEPTH = 512,
	parameter int ADDR_W = 9
) (
	input  logic clk,
	input  ram_req_t req,
	output logic [LINE_W-1:0] rdata
);

	logic [LINE_W-1:0] mem [DEPTH];
	logic [ADDR_W-1:0] addr;

	assign addr = req.row[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (req.wen) begin
			// Keep bits outside the enables
			mem[addr] <= (req.data & req.ben) | (mem[addr] & ~req.ben);
		end
		if (req.ren) begin
			rdata <= mem[addr];
		end
	end

endmodule

/* logic/sweep_counter.sv */
module sweep_counter
	import core_mem_pkg::*;
#(
	parameter int KV_USER_DEPTH = 128,
	parameter int MAX_USERS = 4
) (
	input  logic clk,
	input  logic rstn,
	input  logic load,
	input  logic run,
	input  logic [USER_W-1:0] user,
	output logic [$clog2(KV_USER_DEPTH * MAX_USERS)-1:0] row,
	output logic last_row
);

	localparam int ROW_W = $clog2(KV_USER_DEPTH * MAX_USERS);

	logic [ROW_W-1:0] first_row;
	logic [ROW_W-1:0] end_row;

	assign first_row = ROW_W'(user) * ROW_W'(KV_USER_DEPTH);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			row <= '0;
			end_row <= '0;
		end else if (load) begin
			row <= first_row;
			end_row <= first_row + ROW_W'(KV_USER_DEPTH - 1);
		end else if (run) begin
			row <= row + 1'b1;
		end
	end

	assign last_row = row == end_row;

endmodule

/* logic/weight_bank.sv */
module weight_bank
	import core_mem_pkg::*;
#(
	parameter int WMEM_DEPTH = 1536
) (
	input  logic clk,
	input  logic rstn,
	input  ram_req_t host_req,
	input  cmem_req_t cmem_req,
	output logic [LINE_W-1:0] rdata,
	output logic cmem_rvalid
);

	logic host_act;
	ram_req_t ram_req;

	assign host_act = host_req.wen || host_req.ren;

	// Host wins, compute lines are written whole
	always_comb begin
		if (host_act) begin
			ram_req = host_req;
		end else begin
			ram_req.wen = cmem_req.wen;
			ram_req.ren = cmem_req.ren;
			ram_req.row = cmem_req.addr[RAM_ROW_W-1:0];
			ram_req.data = cmem_req.data;
			ram_req.ben = '1;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cmem_rvalid <= 1'b0;
		end else begin
			cmem_rvalid <= cmem_req.ren && !host_act;
		end
	end

	sp_ram #(
		.DEPTH(WMEM_DEPTH),
		.ADDR_W($clog2(WMEM_DEPTH))
	) u_ram (
		.clk(clk),
		.req(ram_req),
		.rdata(rdata)
	);

endmodule

/* tb/core_mem_model.svh */
`ifndef CORE_MEM_MODEL_SVH
`define CORE_MEM_MODEL_SVH

// Reference contents of both memories
logic [LINE_W-1:0] wm_ref [WMEM_DEPTH];
logic [LINE_W-1:0] kv_ref [KV_ROWS];

// Weight row r lives in region r/512 + 1
function automatic logic [HOST_ADDR_W-1:0] wm_host_addr(int wrow, int word);
	logic [1:0] region;
	logic [8:0] row;
	region = 2'(wrow / REGION_ROWS + 1);
	row = 9'(wrow % REGION_ROWS);
	return {region, row, 3'(word)};
endfunction

function automatic logic [HOST_ADDR_W-1:0] kv_host_addr(int user, int row, int word);
	return {2'b00, 2'(user), 7'(row), 3'(word)};
endfunction

// Bits 11 to 3 give user and row for the cache
function automatic int host_ref_row(logic [HOST_ADDR_W-1:0] addr);
	if (addr[13:12] == 2'd0) begin
		return int'(addr[11:3]);
	end
	return (int'(addr[13:12]) - 1) * REGION_ROWS + int'(addr[11:3]);
endfunction

function automatic void host_write_ref(logic [HOST_ADDR_W-1:0] addr, logic [WORD_W-1:0] data);
	int row;
	int word;
	row = host_ref_row(addr);
	word = int'(addr[2:0]);
	if (addr[13:12] == 2'd0) begin
		kv_ref[row][word * WORD_W +: WORD_W] = data;
	end else begin
		wm_ref[row][word * WORD_W +: WORD_W] = data;
	end
endfunction

function automatic logic [WORD_W-1:0] expect_host_word(logic [HOST_ADDR_W-1:0] addr);
	logic [LINE_W-1:0] line;
	if (addr[13:12] == 2'd0) begin
		line = kv_ref[host_ref_row(addr)];
	end else begin
		line = wm_ref[host_ref_row(addr)];
	end
	return line[int'(addr[2:0]) * WORD_W +: WORD_W];
endfunction

function automatic void cmem_write_ref(logic [CMEM_ADDR_W-1:0] addr, logic [LINE_W-1:0] data,
		int user);
	int lane;
	int row;
	lane = int'(addr[10:7]);
	row = user * KV_USER_DEPTH + int'(addr[6:0]);
	if (addr[CMEM_ADDR_W-1]) begin
		kv_ref[row][lane * LANE_W +: LANE_W] = data[LANE_W-1:0];
	end else begin
		wm_ref[int'(addr[10:0])] = data;
	end
endfunction

function automatic logic [LINE_W-1:0] expect_cmem_line(logic [CMEM_ADDR_W-1:0] addr, int user);
	if (addr[CMEM_ADDR_W-1]) begin
		return kv_ref[user * KV_USER_DEPTH + int'(addr[6:0])];
	end
	return wm_ref[int'(addr[10:0])];
endfunction

function automatic void clean_ref(int user);
	for (int r = 0; r < KV_USER_DEPTH; r++) begin
		kv_ref[user * KV_USER_DEPTH + r] = '0;
	end
endfunction

`endif

/* tb/core_mem_tb.sv */
module core_mem_tb
	import core_mem_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WMEM_DEPTH = 1536;
	localparam int KV_USER_DEPTH = 128;
	localparam int MAX_USERS = 4;
	localparam int KV_ROWS = KV_USER_DEPTH * MAX_USERS;
	localparam int REGION_ROWS = 512;
	localparam int N_HOST_WORDS = 24;
	localparam int N_LINES = 16;
	localparam int N_LANE_WRITES = 16;
	// Accesses over all tests, at most five cycles each, plus three cleans
	localparam int N_OPS = 4 * N_HOST_WORDS + 4 * N_LINES + 8 * N_LANE_WRITES
		+ 2 * KV_USER_DEPTH;
	localparam int MAX_CYCLES = 5 * N_OPS + 3 * (KV_USER_DEPTH + 8) + 50;

	logic clk;
	logic rstn;
	host_req_t host;
	logic [WORD_W-1:0] host_rdata;
	logic host_rvld;
	cmem_req_t cmem;
	logic [LINE_W-1:0] cmem_rdata;
	logic cmem_rvalid;
	logic [USER_W-1:0] active_user;
	logic clean_kv;
	logic [USER_W-1:0] clean_user;
	logic clean_done;

	integer seed = 32'hff0a_b288;
	int cycles = 0;
	logic [LINE_W-1:0] host_exp [$];
	string host_tag [$];
	logic [LINE_W-1:0] line_exp [$];
	string line_tag [$];

	`include "core_mem_model.svh"

	core_mem #(
		.WMEM_DEPTH(WMEM_DEPTH),
		.KV_USER_DEPTH(KV_USER_DEPTH),
		.MAX_USERS(MAX_USERS)
	) UUT (
		.clk(clk),
		.rstn(rstn),
		.host(host),
		.host_rdata(host_rdata),
		.host_rvld(host_rvld),
		.cmem(cmem),
		.cmem_rdata(cmem_rdata),
		.cmem_rvalid(cmem_rvalid),
		.active_user(active_user),
		.clean_kv(clean_kv),
		.clean_user(clean_user),
		.clean_done(clean_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [LINE_W-1:0] expected,
			logic [LINE_W-1:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s expected %0h actual %0h", name, expected, actual);
			stop_run();
		end
	endtask

	function automatic logic [LINE_W-1:0] rand_line();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic int rand_below(int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	task automatic host_write(logic [HOST_ADDR_W-1:0] addr, logic [WORD_W-1:0] data);
		host_req_t req;
		req = '0;
		req.wen = 1'b1;
		req.addr = addr;
		req.wdata = data;
		@(posedge clk);
		host <= req;
		@(posedge clk);
		host <= '0;
		host_write_ref(addr, data);
		@(posedge clk);
	endtask

	task automatic host_read(string name, logic [HOST_ADDR_W-1:0] addr);
		host_req_t req;
		req = '0;
		req.ren = 1'b1;
		req.addr = addr;
		@(posedge clk);
		host <= req;
		host_exp.push_back(LINE_W'(expect_host_word(addr)));
		host_tag.push_back(name);
		@(posedge clk);
		host <= '0;
		while (host_exp.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic cmem_write(logic [CMEM_ADDR_W-1:0] addr, logic [LINE_W-1:0] data);
		cmem_req_t req;
		req = '0;
		req.wen = 1'b1;
		req.addr = addr;
		req.data = data;
		@(posedge clk);
		cmem <= req;
		@(posedge clk);
		cmem <= '0;
		cmem_write_ref(addr, data, int'(active_user));
		@(posedge clk);
	endtask

	task automatic cmem_read(string name, logic [CMEM_ADDR_W-1:0] addr);
		cmem_req_t req;
		req = '0;
		req.ren = 1'b1;
		req.addr = addr;
		@(posedge clk);
		cmem <= req;
		line_exp.push_back(expect_cmem_line(addr, int'(active_user)));
		line_tag.push_back(name);
		@(posedge clk);
		cmem <= '0;
		while (line_exp.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic set_user(int user);
		@(posedge clk);
		active_user <= USER_W'(user);
	endtask

	task automatic run_clean(int user);
		@(posedge clk);
		clean_kv <= 1'b1;
		clean_user <= USER_W'(user);
		@(posedge clk);
		clean_kv <= 1'b0;
		@(negedge clk);
		while (!clean_done) begin
			@(negedge clk);
		end
		// Done is a single-cycle pulse
		@(negedge clk);
		check_value("clean_done pulse", '0, LINE_W'(clean_done));
		clean_ref(user);
		@(posedge clk);
	endtask

	// Compare returned data on the falling edge
	initial begin
		forever begin
			@(negedge clk);
			if (rstn && host_rvld) begin
				if (host_exp.size() == 0) begin
					$display("Host read data was returned with no host read pending");
					stop_run();
				end else begin
					check_value(host_tag.pop_front(), host_exp.pop_front(), LINE_W'(host_rdata));
				end
			end
			if (rstn && cmem_rvalid) begin
				if (line_exp.size() == 0) begin
					$display("Compute read data was returned with no compute read pending");
					stop_run();
				end else begin
					check_value(line_tag.pop_front(), line_exp.pop_front(), cmem_rdata);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with the tests still running", cycles);
			stop_run();
		end
	end

	initial begin : stimulus
		int row;
		int word;
		int lane;
		logic [HOST_ADDR_W-1:0] haddr;
		logic [CMEM_ADDR_W-1:0] caddr;
		int kept_rows [$];
		host = '0;
		cmem = '0;
		active_user = '0;
		clean_kv = 1'b0;
		clean_user = '0;
		rstn = 1'b0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		check_value("reset host_rvld", '0, LINE_W'(host_rvld));
		check_value("reset cmem_rvalid", '0, LINE_W'(cmem_rvalid));
		check_value("reset clean_done", '0, LINE_W'(clean_done));

		// Whole line first so neighbour words are defined
		for (int i = 0; i < N_HOST_WORDS; i++) begin
			row = rand_below(WMEM_DEPTH);
			cmem_write(CMEM_ADDR_W'(row), rand_line());
			word = rand_below(WORDS_PER_LINE);
			haddr = wm_host_addr(row, word);
			host_write(haddr, WORD_W'($random(seed)));
			host_read("host word readback", haddr);
			host_read("host neighbour word", wm_host_addr(row, (word + 1) % WORDS_PER_LINE));
		end

		for (int i = 0; i < N_LINES; i++) begin
			row = rand_below(WMEM_DEPTH);
			caddr = CMEM_ADDR_W'(row);
			cmem_write(caddr, rand_line());
			cmem_read("weight line readback", caddr);
			host_read("weight line slice", wm_host_addr(row, rand_below(WORDS_PER_LINE)));
			host_read("weight line slice", wm_host_addr(row, rand_below(WORDS_PER_LINE)));
		end

		run_clean(1);
		run_clean(2);
		for (int u = 1; u <= 2; u++) begin
			set_user(u);
			for (int i = 0; i < N_LANE_WRITES; i++) begin
				row = rand_below(KV_USER_DEPTH);
				lane = rand_below(LANES);
				caddr = {1'b1, 4'(lane), 7'(row)};
				cmem_write(caddr, rand_line());
				word = rand_below(WORDS_PER_LINE);
				host_write(kv_host_addr(u, row, word), WORD_W'($random(seed)));
				cmem_read("cache lane merge", caddr);
				host_read("cache host word", kv_host_addr(u, row, rand_below(WORDS_PER_LINE)));
				if (u == 2) begin
					kept_rows.push_back(row);
				end
			end
		end

		set_user(1);
		run_clean(1);
		for (int r = 0; r < KV_USER_DEPTH; r++) begin
			cmem_read("cleaned line", {1'b1, 4'd0, 7'(r)});
			host_read("cleaned word", kv_host_addr(1, r, rand_below(WORDS_PER_LINE)));
		end
		set_user(2);
		foreach (kept_rows[k]) begin
			cmem_read("other user kept", {1'b1, 4'd0, 7'(kept_rows[k])});
		end

		repeat (2) @(posedge clk);
		$display("Verification passed");
		$finish;
	end

endmodule
